/* common/chk_timer_settings.svh */
// Global sizes, reseed threshold and reset seed of the check timer
`ifndef CHK_TIMER_SETTINGS_SVH
`define CHK_TIMER_SETTINGS_SVH

// Number of memory partitions served by the scheduler
`define CHK_NUM_PART 4

// LFSR and wait counter width
`define CHK_LFSR_WIDTH 40

// Entropy word width delivered by the entropy source
`define CHK_EDN_WIDTH 64

// Draws taken from the LFSR before new entropy is requested
`define CHK_RESEED_THRESHOLD 4

// Nonzero reset seed
`define CHK_LFSR_SEED 40'h5A_C3E1_9B27

`endif

/* common/chk_timer_pkg.sv */
// Check timer package with the FSM state encoding and the LFSR state type
`include "chk_timer_settings.svh"

package chk_timer_pkg;

  // LFSR state, also the width of both wait counters
  typedef logic [`CHK_LFSR_WIDTH-1:0] lfsr_state_t;

  //////////////////////////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////////////////////////

  localparam int StateWidth = 9;

  // Sparse encoding
  // Pairwise Hamming distance is 5 or 6
  // A single glitch never lands on another legal state
  typedef enum logic [StateWidth-1:0] {
    ResetSt     = 9'b010100101,
    IdleSt      = 9'b111101110,
    IntegWaitSt = 9'b100110011,
    CnstyWaitSt = 9'b001010110,
    ErrorSt     = 9'b111011001
  } timer_state_e;

endpackage

/* common/chk_part_pkg.sv */
// Partition package with per-partition vectors and the escalation word
`include "chk_timer_settings.svh"

package chk_part_pkg;

  // One bit per partition
  typedef logic [`CHK_NUM_PART-1:0] part_vec_t;

  // Multi-bit escalation word
  // Complementary nibbles, so a stuck bit never reads as EscOff
  typedef enum logic [3:0] {
    EscOn  = 4'b1010,
    EscOff = 4'b0101
  } esc_tx_t;

  // Loose test
  // Anything other than the exact off value escalates
  function automatic logic esc_active(esc_tx_t esc);
    return (esc != EscOff);
  endfunction

endpackage

/* rtl/chk_double_lfsr.sv */
// Duplicated Galois LFSR with entropy injection and a copy mismatch error
`include "chk_timer_settings.svh"

module chk_double_lfsr import chk_timer_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        lfsr_en_i,
  input  lfsr_state_t entropy_i,
  output lfsr_state_t state_o,
  output logic        err_o
);

  // Feedback taps for x^40 + x^38 + x^21 + x^19 + 1
  localparam lfsr_state_t Taps = 40'hA0_0014_0000;

  // One right shift, with taps folded in when bit 0 falls out
  // An all-zero result would lock up, so it falls back to the seed
  function automatic lfsr_state_t lfsr_next(lfsr_state_t cur, lfsr_state_t ent);
    lfsr_state_t nxt;
    nxt = cur >> 1;
    if (cur[0]) begin
      nxt = nxt ^ Taps;
    end
    nxt = nxt ^ ent;
    if (nxt == '0) begin
      nxt = `CHK_LFSR_SEED;
    end
    return nxt;
  endfunction

  lfsr_state_t lfsr_q [2];

  // Both copies step in tandem from the same seed
  for (genvar i = 0; i < 2; i++) begin : g_copy
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        lfsr_q[i] <= `CHK_LFSR_SEED;
      end else if (lfsr_en_i) begin
        lfsr_q[i] <= lfsr_next(lfsr_q[i], entropy_i);
      end
    end
  end

  assign state_o = lfsr_q[0];

  // Copies only diverge after a fault
  assign err_o = (lfsr_q[0] != lfsr_q[1]);

endmodule

/* rtl/chk_redun_count.sv */
// Redundant down counter kept as a primary and an inverted copy with a mismatch error
module chk_redun_count #(
  parameter int Width = 40
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             set_i,
  input  logic [Width-1:0] set_val_i,
  input  logic             decr_en_i,
  output logic [Width-1:0] cnt_o,
  output logic             zero_o,
  output logic             err_o
);

  logic [Width-1:0] cnt_q;
  logic [Width-1:0] cnt_n_q;

  // Primary copy counts down and stops at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (set_i) begin
      cnt_q <= set_val_i;
    end else if (decr_en_i && (cnt_q != '0)) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // Inverted copy counts up and stops at all ones
  // Own stop test, so a glitch in one copy is not mirrored
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_n_q <= '1;
    end else if (set_i) begin
      cnt_n_q <= ~set_val_i;
    end else if (decr_en_i && (cnt_n_q != '1)) begin
      cnt_n_q <= cnt_n_q + 1'b1;
    end
  end

  assign cnt_o  = cnt_q;
  assign zero_o = (cnt_q == '0);
  assign err_o  = (cnt_q != ~cnt_n_q);

endmodule

/* chk_timer/chk_timer_regs.sv */
// Check timer register block with write-only configuration, write lock and trigger pulses
module chk_timer_regs (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        reg_we_i,
  input  logic [2:0]  reg_addr_i,
  input  logic [31:0] reg_wdata_i,
  output logic        timer_en_o,
  output logic [31:0] timeout_o,
  output logic [31:0] integ_period_msk_o,
  output logic [31:0] cnsty_period_msk_o,
  output logic        integ_trig_o,
  output logic        cnsty_trig_o
);

  // Register map
  localparam logic [2:0] AddrCtrl  = 3'd0;
  localparam logic [2:0] AddrTmo   = 3'd1;
  localparam logic [2:0] AddrInteg = 3'd2;
  localparam logic [2:0] AddrCnsty = 3'd3;
  localparam logic [2:0] AddrTrig  = 3'd4;
  localparam logic [2:0] AddrLock  = 3'd5;

  logic regwen_q;

  // Lock covers timeout and both masks, not the enable
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      regwen_q           <= 1'b1;
      timer_en_o         <= 1'b0;
      timeout_o          <= '0;
      integ_period_msk_o <= '0;
      cnsty_period_msk_o <= '0;
    end else if (reg_we_i) begin
      unique case (reg_addr_i)
        AddrCtrl:  timer_en_o <= reg_wdata_i[0];
        AddrTmo:   if (regwen_q) timeout_o <= reg_wdata_i;
        AddrInteg: if (regwen_q) integ_period_msk_o <= reg_wdata_i;
        AddrCnsty: if (regwen_q) cnsty_period_msk_o <= reg_wdata_i;
        // Sticky until reset
        AddrLock:  regwen_q <= 1'b0;
        default: ;
      endcase
    end
  end

  // Triggers are not stored and last the write cycle only
  assign integ_trig_o = reg_we_i && (reg_addr_i == AddrTrig) && reg_wdata_i[0];
  assign cnsty_trig_o = reg_we_i && (reg_addr_i == AddrTrig) && reg_wdata_i[1];

endmodule

/* chk_timer/chk_lfsr_timer.sv */
// Check scheduler that draws wait periods, issues partition checks and watches timeouts
`include "chk_timer_settings.svh"

module chk_lfsr_timer import chk_timer_pkg::*; import chk_part_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      timer_en_i,
  input  logic                      prog_busy_i,
  input  logic                      integ_trig_i,
  input  logic                      cnsty_trig_i,
  input  logic [31:0]               timeout_i,
  input  logic [31:0]               integ_period_msk_i,
  input  logic [31:0]               cnsty_period_msk_i,
  input  part_vec_t                 integ_chk_ack_i,
  input  part_vec_t                 cnsty_chk_ack_i,
  input  esc_tx_t                   escalate_i,
  input  logic                      edn_ack_i,
  input  logic [`CHK_EDN_WIDTH-1:0] edn_data_i,
  output logic                      edn_req_o,
  output logic                      chk_pending_o,
  output part_vec_t                 integ_chk_req_o,
  output part_vec_t                 cnsty_chk_req_o,
  output logic                      chk_timeout_o,
  output logic                      fsm_err_o
);

  localparam int W = `CHK_LFSR_WIDTH;
  localparam int CntW = $clog2(`CHK_RESEED_THRESHOLD + 1);

  ////////////////////////////////////////////////////////////////////////
  // Reseed counter
  ////////////////////////////////////////////////////////////////////////

  logic draw_en, reseed_en;
  logic [CntW-1:0] reseed_cnt_q;

  // Draws are not counted while a reseed is outstanding
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reseed_cnt_q <= '0;
    end else if (reseed_en) begin
      reseed_cnt_q <= '0;
    end else if (draw_en && !edn_req_o) begin
      reseed_cnt_q <= reseed_cnt_q + 1'b1;
    end
  end

  // Level request while the timer keeps running
  assign edn_req_o = (reseed_cnt_q >= CntW'(`CHK_RESEED_THRESHOLD));
  assign reseed_en = edn_req_o && edn_ack_i;

  ////////////////////////////////////////////////////////////////////////
  // LFSR and wait counters
  ////////////////////////////////////////////////////////////////////////

  lfsr_state_t lfsr_state, entropy;
  logic        lfsr_err;

  // Low entropy bits only
  assign entropy = reseed_en ? edn_data_i[W-1:0] : '0;

  chk_double_lfsr u_lfsr (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .lfsr_en_i (draw_en || reseed_en),
    .entropy_i (entropy),
    .state_o   (lfsr_state),
    .err_o     (lfsr_err)
  );

  logic integ_set_period, integ_set_timeout, integ_zero, integ_err;
  logic cnsty_set_period, cnsty_set_timeout, cnsty_zero, cnsty_err;
  logic cnsty_pause, timeout_zero;
  lfsr_state_t integ_mask, cnsty_mask, timeout_val, integ_set_val, cnsty_set_val;

  // 32-bit mask above eight always-set bits
  assign integ_mask   = {integ_period_msk_i, {(W-32){1'b1}}};
  assign cnsty_mask   = {cnsty_period_msk_i, {(W-32){1'b1}}};
  assign timeout_val  = {{(W-32){1'b0}}, timeout_i};
  assign timeout_zero = (timeout_i == '0);

  // Period draw on completion, timeout on entering a wait state
  assign integ_set_val = integ_set_period ? (lfsr_state & integ_mask) : timeout_val;
  assign cnsty_set_val = cnsty_set_period ? (lfsr_state & cnsty_mask) : timeout_val;

  chk_redun_count #(
    .Width (W)
  ) u_integ_cnt (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .set_i     (integ_set_period || integ_set_timeout),
    .set_val_i (integ_set_val),
    .decr_en_i (1'b1),
    .cnt_o     (),
    .zero_o    (integ_zero),
    .err_o     (integ_err)
  );

  // Held while programming is busy
  chk_redun_count #(
    .Width (W)
  ) u_cnsty_cnt (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .set_i     (cnsty_set_period || cnsty_set_timeout),
    .set_val_i (cnsty_set_val),
    .decr_en_i (!cnsty_pause),
    .cnt_o     (),
    .zero_o    (cnsty_zero),
    .err_o     (cnsty_err)
  );

  ////////////////////////////////////////////////////////////////////////
  // Trigger latches and request vectors
  ////////////////////////////////////////////////////////////////////////

  logic integ_trig_q, cnsty_trig_q, clr_integ_trig, clr_cnsty_trig;
  logic set_integ_reqs, set_cnsty_reqs, clr_all_reqs;
  part_vec_t integ_req_q, cnsty_req_q;
  timer_state_e state_d, state_q;
  logic chk_timeout_d;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      integ_trig_q  <= 1'b0;
      cnsty_trig_q  <= 1'b0;
      integ_req_q   <= '0;
      cnsty_req_q   <= '0;
      chk_timeout_o <= 1'b0;
      state_q       <= ResetSt;
    end else begin
      // Triggers are ignored while disabled or in error
      integ_trig_q  <= (integ_trig_q && !clr_integ_trig) ||
                       (integ_trig_i && timer_en_i && !clr_all_reqs);
      cnsty_trig_q  <= (cnsty_trig_q && !clr_cnsty_trig) ||
                       (cnsty_trig_i && timer_en_i && !clr_all_reqs);
      // Set all bits, else drop each bit on its ack
      integ_req_q   <= set_integ_reqs ? '1 :
                       clr_all_reqs   ? '0 : (integ_req_q & ~integ_chk_ack_i);
      cnsty_req_q   <= set_cnsty_reqs ? '1 :
                       clr_all_reqs   ? '0 : (cnsty_req_q & ~cnsty_chk_ack_i);
      chk_timeout_o <= chk_timeout_d;
      state_q       <= state_d;
    end
  end

  assign integ_chk_req_o = integ_req_q;
  assign cnsty_chk_req_o = cnsty_req_q;

  ////////////////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d           = state_q;
    chk_timeout_d     = chk_timeout_o;
    draw_en           = 1'b0;
    integ_set_period  = 1'b0;
    cnsty_set_period  = 1'b0;
    integ_set_timeout = 1'b0;
    cnsty_set_timeout = 1'b0;
    cnsty_pause       = 1'b0;
    set_integ_reqs    = 1'b0;
    set_cnsty_reqs    = 1'b0;
    clr_all_reqs      = 1'b0;
    clr_integ_trig    = 1'b0;
    clr_cnsty_trig    = 1'b0;
    chk_pending_o     = integ_trig_q || cnsty_trig_q;
    fsm_err_o         = 1'b0;

    unique case (state_q)
      // Leaves only once, when first enabled
      ResetSt: begin
        if (timer_en_i) begin
          state_d = IdleSt;
          draw_en = 1'b1;
        end
      end
      // Integrity wins when both kinds are due
      IdleSt: begin
        if ((integ_period_msk_i != '0 && integ_zero) || integ_trig_q) begin
          state_d           = IntegWaitSt;
          integ_set_timeout = 1'b1;
          set_integ_reqs    = 1'b1;
          clr_integ_trig    = 1'b1;
        end else if ((cnsty_period_msk_i != '0 && cnsty_zero) || cnsty_trig_q) begin
          state_d           = CnstyWaitSt;
          cnsty_set_timeout = 1'b1;
          set_cnsty_reqs    = 1'b1;
          clr_cnsty_trig    = 1'b1;
        end
      end
      // Wait for every partition, then draw the next period
      IntegWaitSt: begin
        chk_pending_o = 1'b1;
        if (!timeout_zero && integ_zero) begin
          state_d       = ErrorSt;
          chk_timeout_d = 1'b1;
        end else if (integ_req_q == '0) begin
          state_d          = IdleSt;
          integ_set_period = 1'b1;
          draw_en          = 1'b1;
        end
      end
      // Programming can stall reads, so the timeout holds meanwhile
      CnstyWaitSt: begin
        chk_pending_o = 1'b1;
        cnsty_pause   = prog_busy_i;
        if (!timeout_zero && cnsty_zero) begin
          state_d       = ErrorSt;
          chk_timeout_d = 1'b1;
        end else if (cnsty_req_q == '0) begin
          state_d          = IdleSt;
          cnsty_set_period = 1'b1;
          draw_en          = 1'b1;
        end
      end
      // Terminal state that drops all requests and pending triggers
      ErrorSt: begin
        clr_all_reqs   = 1'b1;
        clr_integ_trig = 1'b1;
        clr_cnsty_trig = 1'b1;
        fsm_err_o      = !chk_timeout_o;
      end
      // Illegal encoding
      default: begin
        state_d   = ErrorSt;
        fsm_err_o = 1'b1;
      end
    endcase

    // Escalation or any copy mismatch overrides everything above
    if (lfsr_err || integ_err || cnsty_err || esc_active(escalate_i)) begin
      state_d   = ErrorSt;
      fsm_err_o = 1'b1;
    end
  end

endmodule

/* rtl/chk_timer_top.sv */
// Check timer top level joining the register block to the check scheduler
`include "chk_timer_settings.svh"

module chk_timer_top import chk_part_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Register bus
  input  logic                      reg_we_i,
  input  logic [2:0]                reg_addr_i,
  input  logic [31:0]               reg_wdata_i,
  // Status from the memory controller
  input  logic                      prog_busy_i,
  input  esc_tx_t                   escalate_i,
  // Partitions
  input  part_vec_t                 integ_chk_ack_i,
  input  part_vec_t                 cnsty_chk_ack_i,
  output part_vec_t                 integ_chk_req_o,
  output part_vec_t                 cnsty_chk_req_o,
  // Entropy source
  input  logic                      edn_ack_i,
  input  logic [`CHK_EDN_WIDTH-1:0] edn_data_i,
  output logic                      edn_req_o,
  // Status
  output logic                      chk_pending_o,
  output logic                      chk_timeout_o,
  output logic                      fsm_err_o
);

  logic        timer_en, integ_trig, cnsty_trig;
  logic [31:0] timeout, integ_msk, cnsty_msk;

  chk_timer_regs u_regs (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .reg_we_i           (reg_we_i),
    .reg_addr_i         (reg_addr_i),
    .reg_wdata_i        (reg_wdata_i),
    .timer_en_o         (timer_en),
    .timeout_o          (timeout),
    .integ_period_msk_o (integ_msk),
    .cnsty_period_msk_o (cnsty_msk),
    .integ_trig_o       (integ_trig),
    .cnsty_trig_o       (cnsty_trig)
  );

  chk_lfsr_timer u_timer (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .timer_en_i         (timer_en),
    .prog_busy_i        (prog_busy_i),
    .integ_trig_i       (integ_trig),
    .cnsty_trig_i       (cnsty_trig),
    .timeout_i          (timeout),
    .integ_period_msk_i (integ_msk),
    .cnsty_period_msk_i (cnsty_msk),
    .integ_chk_ack_i    (integ_chk_ack_i),
    .cnsty_chk_ack_i    (cnsty_chk_ack_i),
    .escalate_i         (escalate_i),
    .edn_ack_i          (edn_ack_i),
    .edn_data_i         (edn_data_i),
    .edn_req_o          (edn_req_o),
    .chk_pending_o      (chk_pending_o),
    .integ_chk_req_o    (integ_chk_req_o),
    .cnsty_chk_req_o    (cnsty_chk_req_o),
    .chk_timeout_o      (chk_timeout_o),
    .fsm_err_o          (fsm_err_o)
  );

endmodule

/* tb/chk_timer_sva.sv */
// Scheduler assertions on request set and clear, sticky timeout and known outputs
module chk_timer_sva import chk_timer_pkg::*; import chk_part_pkg::*; (
  input logic         clk_i,
  input logic         rst_ni,
  input timer_state_e state_q,
  input part_vec_t    integ_chk_req_o,
  input part_vec_t    cnsty_chk_req_o,
  input part_vec_t    integ_chk_ack_i,
  input part_vec_t    cnsty_chk_ack_i,
  input logic         edn_req_o,
  input logic         chk_pending_o,
  input logic         chk_timeout_o,
  input logic         fsm_err_o
);

  timeunit 1ns;
  timeprecision 100ps;

  // Number of failed assertions
  int unsigned fail_cnt = 0;

  // New request bits only come out of IdleSt
  req_set_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (|((integ_chk_req_o & ~$past(integ_chk_req_o)) |
       (cnsty_chk_req_o & ~$past(cnsty_chk_req_o))))
    |-> ($past(state_q) == IdleSt))
    else begin
      fail_cnt++;
      $error("request set outside IdleSt");
    end

  // A request bit drops only on its ack, or when the FSM is in error
  req_clr_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((($past(integ_chk_req_o) & ~integ_chk_req_o & ~$past(integ_chk_ack_i)) == '0 &&
      ($past(cnsty_chk_req_o) & ~cnsty_chk_req_o & ~$past(cnsty_chk_ack_i)) == '0) ||
     $past(state_q) == ErrorSt))
    else begin
      fail_cnt++;
      $error("request dropped without ack");
    end

  // Timeout is sticky until reset
  timeout_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$fell(chk_timeout_o))
    else begin
      fail_cnt++;
      $error("timeout flag fell");
    end

  outputs_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown({integ_chk_req_o, cnsty_chk_req_o, edn_req_o, chk_pending_o,
                 chk_timeout_o, fsm_err_o}))
    else begin
      fail_cnt++;
      $error("unknown value on an output");
    end

endmodule

bind chk_lfsr_timer chk_timer_sva u_sva (.*);

/* tb/chk_timer_tb.sv */
// Directed testbench of the check timer with partition and entropy models
`include "chk_timer_settings.svh"

module chk_timer_tb import chk_part_pkg::*;;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int ClkPeriod = 4;
  localparam int NumPart   = `CHK_NUM_PART;

  // Per-test cycle budgets summed for the watchdog
  localparam int TestBudget = 500 + 500 + 6500 + 800 + 600 + 300;
  localparam int Margin     = 10800;

  // Register map
  localparam logic [2:0] AddrCtrl  = 3'd0;
  localparam logic [2:0] AddrTmo   = 3'd1;
  localparam logic [2:0] AddrInteg = 3'd2;
  localparam logic [2:0] AddrCnsty = 3'd3;
  localparam logic [2:0] AddrTrig  = 3'd4;
  localparam logic [2:0] AddrLock  = 3'd5;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      reg_we;
  logic [2:0]                reg_addr;
  logic [31:0]               reg_wdata;
  logic                      prog_busy;
  esc_tx_t                   escalate;
  part_vec_t                 integ_ack, cnsty_ack;
  part_vec_t                 integ_req, cnsty_req;
  logic                      edn_ack, edn_req;
  logic [`CHK_EDN_WIDTH-1:0] edn_data;
  logic                      chk_pending, chk_timeout, fsm_err;

  chk_timer_top UUT (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .reg_we_i        (reg_we),
    .reg_addr_i      (reg_addr),
    .reg_wdata_i     (reg_wdata),
    .prog_busy_i     (prog_busy),
    .escalate_i      (escalate),
    .integ_chk_ack_i (integ_ack),
    .cnsty_chk_ack_i (cnsty_ack),
    .integ_chk_req_o (integ_req),
    .cnsty_chk_req_o (cnsty_req),
    .edn_ack_i       (edn_ack),
    .edn_data_i      (edn_data),
    .edn_req_o       (edn_req),
    .chk_pending_o   (chk_pending),
    .chk_timeout_o   (chk_timeout),
    .fsm_err_o       (fsm_err)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Reporting
  //////////////////////////////////////////////////////////////////////

  task automatic report_failure();
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_eq(string name, logic [63:0] got, logic [63:0] exp);
    if (got !== exp) begin
      $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
      report_failure();
    end
  endtask

  task automatic report_stuck(string what);
    $display("%s", what);
    report_failure();
  endtask

  initial begin
    #(longint'(TestBudget + Margin) * ClkPeriod);
    $display("Watchdog expired before the tests finished");
    report_failure();
  end

  initial begin
    wait (UUT.u_timer.u_sva.fail_cnt != 0);
    $display("An assertion on the scheduler failed");
    report_failure();
  end

  //////////////////////////////////////////////////////////////////////
  // Partition and entropy models
  //////////////////////////////////////////////////////////////////////

  logic [15:0] rnd_q = 16'd78;
  int          integ_cnt [NumPart];
  int          cnsty_cnt [NumPart];
  logic        integ_hold, cnsty_hold, edn_hold;
  int          edn_wait;

  function automatic logic [15:0] galois_step(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // Three LFSR steps give one delay of 0 to 7 cycles
  task automatic draw_delay(output int d);
    d = 0;
    for (int i = 0; i < 3; i++) begin
      rnd_q = galois_step(rnd_q);
      d = (d << 1) | int'(rnd_q[0]);
    end
  endtask

  // Wait a random delay on one partition bit, then pulse ack for one cycle
  task automatic step_part(input logic req, input logic hold, inout logic ack, inout int cnt);
    if (ack) begin
      ack = 1'b0;
    end else if (!req) begin
      cnt = -1;
    end else if (hold) begin
      cnt = cnt;
    end else if (cnt < 0) begin
      draw_delay(cnt);
    end else if (cnt == 0) begin
      ack = 1'b1;
      cnt = -1;
    end else begin
      cnt--;
    end
  endtask

  always @(negedge clk_i) begin
    for (int b = 0; b < NumPart; b++) begin
      step_part(integ_req[b], integ_hold, integ_ack[b], integ_cnt[b]);
      step_part(cnsty_req[b], cnsty_hold, cnsty_ack[b], cnsty_cnt[b]);
    end
  end

  // Entropy source acks two cycles after the request is seen
  always @(negedge clk_i) begin
    if (edn_ack) begin
      edn_ack  = 1'b0;
      edn_wait = 0;
    end else if (edn_req && !edn_hold) begin
      edn_wait++;
      if (edn_wait >= 2) begin
        edn_ack  = 1'b1;
        edn_data = edn_data + 64'h9E37_79B9_7F4A_7C15;
      end
    end else begin
      edn_wait = 0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Bus and sequencing helpers
  //////////////////////////////////////////////////////////////////////

  task automatic apply_reset();
    @(negedge clk_i);
    rst_ni = 1'b0;
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
  endtask

  // Strobe for one cycle and return on the falling edge after it
  task automatic write_reg(logic [2:0] addr, logic [31:0] data);
    @(negedge clk_i);
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk_i);
    reg_we    = 1'b0;
  endtask

  // Enable, then let the FSM leave ResetSt
  task automatic enable_timer();
    write_reg(AddrCtrl, 32'h1);
    @(negedge clk_i);
  endtask

  task automatic wait_idle(int limit);
    int n;
    n = 0;
    while (chk_pending) begin
      if (n > limit) report_stuck("Check still pending after the wait limit");
      @(negedge clk_i);
      n++;
    end
  endtask

  task automatic run_integ_check();
    int n;
    write_reg(AddrTrig, 32'h1);
    n = 0;
    while (integ_req != '1) begin
      if (n > 4) report_stuck("Integrity requests did not rise after a trigger");
      @(negedge clk_i);
      n++;
    end
    wait_idle(100);
  endtask

  // Checks the other kind stays quiet while measuring the gap of one kind
  task automatic measure_gaps(bit is_cnsty, int bound, int count);
    int n;
    n = 0;
    while ((is_cnsty ? cnsty_req : integ_req) == '0) begin
      if (n > bound + 200) report_stuck("First periodic check never started");
      @(negedge clk_i);
      n++;
    end
    for (int k = 0; k < count; k++) begin
      n = 0;
      while ((is_cnsty ? cnsty_req : integ_req) != '0) begin
        if (n > 100) report_stuck("Periodic check was never acknowledged");
        @(negedge clk_i);
        n++;
      end
      n = 0;
      while ((is_cnsty ? cnsty_req : integ_req) == '0) begin
        check_eq(is_cnsty ? "integ_chk_req_o" : "cnsty_chk_req_o",
                 is_cnsty ? integ_req : cnsty_req, '0);
        if (n > bound + 4) report_stuck("Gap between periodic checks exceeds the bound");
        @(negedge clk_i);
        n++;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_basic_trigger();
    check_eq("integ_chk_req_o", integ_req, '0);
    check_eq("cnsty_chk_req_o", cnsty_req, '0);
    check_eq("edn_req_o", edn_req, 0);
    check_eq("chk_pending_o", chk_pending, 0);
    check_eq("chk_timeout_o", chk_timeout, 0);
    check_eq("fsm_err_o", fsm_err, 0);
    // Trigger is dropped while disabled
    write_reg(AddrTrig, 32'h3);
    repeat (10) begin
      @(negedge clk_i);
      check_eq("integ_chk_req_o", integ_req, '0);
      check_eq("chk_pending_o", chk_pending, 0);
    end
    enable_timer();
    write_reg(AddrTrig, 32'h1);
    check_eq("integ_chk_req_o", integ_req, '0);
    @(negedge clk_i);
    // Two edges after the strobe
    check_eq("integ_chk_req_o", integ_req, 4'hF);
    check_eq("cnsty_chk_req_o", cnsty_req, '0);
    check_eq("chk_pending_o", chk_pending, 1);
    wait_idle(100);
    check_eq("integ_chk_req_o", integ_req, '0);
  endtask

  task automatic test_priority();
    int n;
    write_reg(AddrTrig, 32'h3);
    n = 0;
    while (integ_req != '1) begin
      check_eq("cnsty_chk_req_o", cnsty_req, '0);
      if (n > 4) report_stuck("Integrity requests did not rise after both triggers");
      @(negedge clk_i);
      n++;
    end
    n = 0;
    while (cnsty_req == '0) begin
      if (n > 100) report_stuck("Consistency requests never followed");
      @(negedge clk_i);
      n++;
    end
    check_eq("integ_chk_req_o", integ_req, '0);
    check_eq("cnsty_chk_req_o", cnsty_req, 4'hF);
    wait_idle(100);
  endtask

  task automatic test_periodic();
    // Bounds are the mask above eight ones
    write_reg(AddrInteg, 32'h1);
    measure_gaps(1'b0, 32'h1FF, 3);
    write_reg(AddrInteg, 32'h0);
    write_reg(AddrCnsty, 32'h2);
    measure_gaps(1'b1, 32'h2FF, 3);
    write_reg(AddrCnsty, 32'h0);
    wait_idle(200);
    repeat (2000) begin
      @(negedge clk_i);
      check_eq("integ_chk_req_o", integ_req, '0);
      check_eq("cnsty_chk_req_o", cnsty_req, '0);
    end
  endtask

  task automatic test_reseed();
    int n;
    edn_hold = 1'b1;
    n = 0;
    while (!edn_req) begin
      if (n > 4) report_stuck("Entropy request did not rise after four draws");
      run_integ_check();
      n++;
    end
    // Checks keep running while the reseed is outstanding
    repeat (2) begin
      run_integ_check();
      check_eq("edn_req_o", edn_req, 1);
    end
    edn_hold = 1'b0;
    n = 0;
    while (edn_req) begin
      if (n > 10) report_stuck("Entropy request did not fall after the ack");
      @(negedge clk_i);
      n++;
    end
    edn_hold = 1'b1;
    repeat (3) begin
      run_integ_check();
      check_eq("edn_req_o", edn_req, 0);
    end
    run_integ_check();
    check_eq("edn_req_o", edn_req, 1);
    edn_hold = 1'b0;
    repeat (10) @(negedge clk_i);
    check_eq("edn_req_o", edn_req, 0);
  endtask

  // Withheld consistency acks with an optional busy window from the request onward
  task automatic timeout_run(int busy_cycles);
    int n;
    apply_reset();
    enable_timer();
    write_reg(AddrTmo, 32'd50);
    write_reg(AddrLock, 32'h1);
    // Ignored while the register is locked
    write_reg(AddrTmo, 32'd0);
    cnsty_hold = 1'b1;
    write_reg(AddrTrig, 32'h2);
    @(negedge clk_i);
    check_eq("cnsty_chk_req_o", cnsty_req, 4'hF);
    n = 0;
    while (!chk_timeout) begin
      if (n > 53 + busy_cycles) report_stuck("Timeout did not fire in time");
      prog_busy = (n < busy_cycles);
      @(negedge clk_i);
      n++;
    end
    prog_busy = 1'b0;
    if (n < 50 + busy_cycles) report_stuck("Timeout fired before the programmed period");
    @(negedge clk_i);
    check_eq("fsm_err_o", fsm_err, 0);
    check_eq("cnsty_chk_req_o", cnsty_req, '0);
    write_reg(AddrTrig, 32'h3);
    repeat (50) begin
      @(negedge clk_i);
      check_eq("integ_chk_req_o", integ_req, '0);
      check_eq("cnsty_chk_req_o", cnsty_req, '0);
      check_eq("chk_timeout_o", chk_timeout, 1);
      check_eq("fsm_err_o", fsm_err, 0);
    end
    cnsty_hold = 1'b0;
  endtask

  task automatic test_timeout();
    timeout_run(0);
    timeout_run(30);
  endtask

  task automatic test_escalation();
    apply_reset();
    enable_timer();
    check_eq("fsm_err_o", fsm_err, 0);
    escalate = esc_tx_t'(4'b0000);
    @(negedge clk_i);
    check_eq("fsm_err_o", fsm_err, 1);
    escalate = EscOff;
    write_reg(AddrTrig, 32'h3);
    repeat (50) begin
      @(negedge clk_i);
      check_eq("fsm_err_o", fsm_err, 1);
      check_eq("integ_chk_req_o", integ_req, '0);
      check_eq("cnsty_chk_req_o", cnsty_req, '0);
      check_eq("chk_pending_o", chk_pending, 0);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_ni     = 1'b0;
    reg_we     = 1'b0;
    reg_addr   = '0;
    reg_wdata  = '0;
    prog_busy  = 1'b0;
    escalate   = EscOff;
    integ_ack  = '0;
    cnsty_ack  = '0;
    edn_ack    = 1'b0;
    edn_data   = 64'h0123_4567_89AB_CDEF;
    integ_hold = 1'b0;
    cnsty_hold = 1'b0;
    edn_hold   = 1'b0;
    edn_wait   = 0;
    for (int b = 0; b < NumPart; b++) begin
      integ_cnt[b] = -1;
      cnsty_cnt[b] = -1;
    end
    apply_reset();
    test_basic_trigger();
    test_priority();
    test_periodic();
    test_reseed();
    test_timeout();
    test_escalation();
    repeat (4) @(negedge clk_i);
    $display("Regression passed");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+common
common/chk_timer_pkg.sv
common/chk_part_pkg.sv
rtl/chk_double_lfsr.sv
rtl/chk_redun_count.sv
chk_timer/chk_timer_regs.sv
chk_timer/chk_lfsr_timer.sv
rtl/chk_timer_top.sv
tb/chk_timer_sva.sv
tb/chk_timer_tb.sv
